// File: Makefile
# Verilator flow for the sorted priority queue
TOP       ?= tb_pq_top
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
FAIL_MSG  := Simulation failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# A crashed or aborted run also leaves the fail message in the log
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Failure found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: list.f
src/pq_data_pkg.sv
src/pq_ctrl_pkg.sv
src/value_router.sv
src/queue_ram.sv
src/queue_ctrl.sv
src/pq_top.sv
testbench/tb_pq_top.sv

// File: src/pq_ctrl_pkg.sv
`default_nettype none

package pq_ctrl_pkg;

   // Router step codes, driven by the controller
   typedef enum logic [2:0] {
      ROUTE_CMP   = 3'b000,  // compare and swap against holding word
      ROUTE_INC   = 3'b001,  // Count up after a push
      ROUTE_SHIFT = 3'b011,  // Read word passed straight to write data
      ROUTE_DEC   = 3'b100,  // Count down after a pop
      ROUTE_IDLE  = 3'b111   // Neutral outputs
   } route_t;

   // Controller FSM states
   typedef enum logic [3:0] {
      ST_INIT     = 4'd0,
      ST_IDLE     = 4'd1,
      ST_PUSH_RD  = 4'd2,
      ST_PUSH_WR  = 4'd3,
      ST_PUSH_END = 4'd4,
      ST_POP_RD   = 4'd5,
      ST_POP_WR   = 4'd6,
      ST_POP_END  = 4'd7
   } ctrl_state_t;

endpackage : pq_ctrl_pkg

`default_nettype wire

// File: src/pq_data_pkg.sv
`default_nettype none

package pq_data_pkg;

   // Default word width of a queue entry
   localparam int DEF_WIDTH = 32;

   // Default number of slots in the queue RAM
   localparam int DEF_DEPTH = 16;

   // End marker rule
   // The all-ones word of the active WIDTH fills every unused slot.
   // Each module builds it from its own WIDTH, so no fixed constant here.
   // The all-ones word is therefore never a legal payload.

endpackage : pq_data_pkg

`default_nettype wire

// File: src/pq_top.sv
`timescale 1ns/1ps
`default_nettype none

module pq_top
   import pq_data_pkg::*;
   import pq_ctrl_pkg::*;
#(
   parameter int WIDTH = DEF_WIDTH,
   parameter int DEPTH = DEF_DEPTH,
   localparam int AW = $clog2(DEPTH)
) (
   input  wire logic             clk,
   input  wire logic             rst,
   // Push side
   input  wire logic             push,
   input  wire logic [WIDTH-1:0] push_data,
   // Pop side
   input  wire logic             pop,
   output logic      [WIDTH-1:0] pop_data,
   output logic                  pop_valid,
   // Status
   output logic                  busy,
   output logic                  full,
   output logic                  empty,
   output logic      [AW:0]      count
);

   // Controller to RAM and router
   logic [AW-1:0]    mem_addr;
   logic             mem_we;
   route_t           route_mode;
   logic [WIDTH-1:0] hold_value;

   // RAM read data
   logic [WIDTH-1:0] mem_rdata;

   // Router results
   logic [WIDTH-1:0] mem_wdata;
   logic [WIDTH-1:0] hold_next;
   logic [AW:0]      count_next;
   logic             swap;
   logic             at_end;
   logic             full_next;
   logic             empty_next;

   ////////////////////////////////////////////////////////////////////////////
   // Controller
   ////////////////////////////////////////////////////////////////////////////

   queue_ctrl #(
      .WIDTH (WIDTH),
      .DEPTH (DEPTH)
   ) u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .push       (push),
      .push_data  (push_data),
      .pop        (pop),
      .mem_rdata  (mem_rdata),
      .mem_wdata  (mem_wdata),
      .hold_next  (hold_next),
      .count_next (count_next),
      .swap       (swap),
      .at_end     (at_end),
      .full_next  (full_next),
      .empty_next (empty_next),
      .mem_addr   (mem_addr),
      .mem_we     (mem_we),
      .route_mode (route_mode),
      .hold_value (hold_value),
      .count      (count),
      .pop_data   (pop_data),
      .pop_valid  (pop_valid),
      .busy       (busy),
      .full       (full),
      .empty      (empty)
   );

   // Compare, shift and count steps
   value_router #(
      .WIDTH (WIDTH),
      .DEPTH (DEPTH)
   ) u_router (
      .mem_rdata  (mem_rdata),
      .hold_value (hold_value),
      .route_mode (route_mode),
      .count      (count),
      .mem_wdata  (mem_wdata),
      .hold_next  (hold_next),
      .count_next (count_next),
      .swap       (swap),
      .at_end     (at_end),
      .full_next  (full_next),
      .empty_next (empty_next)
   );

   // Sorted storage, front at address 0
   queue_ram #(
      .WIDTH (WIDTH),
      .DEPTH (DEPTH)
   ) u_ram (
      .clk       (clk),
      .mem_addr  (mem_addr),
      .mem_we    (mem_we),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

endmodule : pq_top

`default_nettype wire

// File: src/queue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module queue_ctrl
   import pq_data_pkg::*;
   import pq_ctrl_pkg::*;
#(
   parameter int WIDTH = DEF_WIDTH,
   parameter int DEPTH = DEF_DEPTH,
   localparam int AW = $clog2(DEPTH)
) (
   input  wire logic             clk,
   input  wire logic             rst,
   // Requests
   input  wire logic             push,
   input  wire logic [WIDTH-1:0] push_data,
   input  wire logic             pop,
   // RAM read port and router results
   input  wire logic [WIDTH-1:0] mem_rdata,
   input  wire logic [WIDTH-1:0] mem_wdata,
   input  wire logic [WIDTH-1:0] hold_next,
   input  wire logic [AW:0]      count_next,
   input  wire logic             swap,
   input  wire logic             at_end,
   input  wire logic             full_next,
   input  wire logic             empty_next,
   // RAM and router control
   output logic      [AW-1:0]    mem_addr,
   output logic                  mem_we,
   output route_t                route_mode,
   output logic      [WIDTH-1:0] hold_value,
   output logic      [AW:0]      count,
   // Status and pop result
   output logic      [WIDTH-1:0] pop_data,
   output logic                  pop_valid,
   output logic                  busy,
   output logic                  full,
   output logic                  empty
);

   // End marker for this word width
   localparam logic [WIDTH-1:0] END_WORD  = {WIDTH{1'b1}};
   // Highest slot address
   localparam logic [AW-1:0]    LAST_ADDR = AW'(DEPTH - 1);

   ctrl_state_t      state;
   ctrl_state_t      state_next;
   // Scan address, slot being read
   logic [AW-1:0]    addr;
   logic             read_end;

   // Read word is the end marker
   assign read_end = (mem_rdata == END_WORD);

   ////////////////////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_next = state;
      case (state)
         ST_INIT: begin
            // First cycle after reset only raises busy
            if (busy && addr == LAST_ADDR) begin
               state_next = ST_IDLE;
            end
         end
         ST_IDLE: begin
            // Push wins over pop
            if (push && !full) begin
               state_next = ST_PUSH_RD;
            end else if (pop && !empty) begin
               state_next = ST_POP_RD;
            end
         end
         ST_PUSH_RD: state_next = ST_PUSH_WR;
         ST_PUSH_WR: begin
            // Stop once the end marker took the carried word
            state_next = at_end ? ST_PUSH_END : ST_PUSH_RD;
         end
         ST_PUSH_END: state_next = ST_IDLE;
         ST_POP_RD:   state_next = ST_POP_WR;
         ST_POP_WR: begin
            // Slot 0 read is the front word, shift starts after it
            if (addr != '0 && (read_end || addr == LAST_ADDR)) begin
               state_next = ST_POP_END;
            end else begin
               state_next = ST_POP_RD;
            end
         end
         ST_POP_END:  state_next = ST_IDLE;
         default:     state_next = ST_IDLE;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // RAM address, write enable and router step
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      route_mode = ROUTE_IDLE;
      mem_we     = 1'b0;
      mem_addr   = addr;
      case (state)
         // Router idle drives the end marker
         ST_INIT:     mem_we = busy;
         ST_PUSH_WR: begin
            route_mode = ROUTE_CMP;
            // Slot unchanged unless swapped
            mem_we     = swap;
         end
         ST_PUSH_END: route_mode = ROUTE_INC;
         ST_POP_WR: begin
            route_mode = ROUTE_SHIFT;
            // Write one slot below the read
            mem_addr   = addr - 1'b1;
            mem_we     = (addr != '0);
         end
         ST_POP_END: begin
            // End marker behind the last word
            route_mode = ROUTE_DEC;
            mem_we     = 1'b1;
         end
         default: begin
            route_mode = ROUTE_IDLE;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= ST_INIT;
         addr      <= '0;
         busy      <= 1'b0;
         pop_valid <= 1'b0;
         count     <= '0;
         full      <= 1'b0;
         empty     <= 1'b1;
      end else begin
         state     <= state_next;
         busy      <= (state_next != ST_IDLE);
         pop_valid <= 1'b0;
         case (state)
            ST_INIT: begin
               if (busy) begin
                  addr <= addr + 1'b1;
               end
            end
            // Every scan starts at the front
            ST_IDLE:    addr <= '0;
            ST_PUSH_WR: begin
               if (!at_end) begin
                  addr <= addr + 1'b1;
               end
            end
            ST_POP_WR: begin
               if (addr == '0) begin
                  pop_valid <= 1'b1;
               end
               if (state_next == ST_POP_RD) begin
                  addr <= addr + 1'b1;
               end
            end
            ST_PUSH_END, ST_POP_END: begin
               count <= count_next;
               full  <= full_next;
               empty <= empty_next;
            end
            default: begin
               addr <= addr;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Payload registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      // Holding word, loaded on an accepted push
      if (state == ST_IDLE && state_next == ST_PUSH_RD) begin
         hold_value <= push_data;
      end else if (state == ST_PUSH_WR) begin
         hold_value <= hold_next;
      end
      // Front word through the shift path
      if (state == ST_POP_WR && addr == '0) begin
         pop_data <= mem_wdata;
      end
   end

endmodule : queue_ctrl

`default_nettype wire

// File: src/queue_ram.sv
`timescale 1ns/1ps
`default_nettype none

module queue_ram
   import pq_data_pkg::*;
#(
   parameter int WIDTH = DEF_WIDTH,
   parameter int DEPTH = DEF_DEPTH,
   localparam int AW = $clog2(DEPTH)
) (
   input  wire logic             clk,
   input  wire logic [AW-1:0]    mem_addr,
   input  wire logic             mem_we,
   input  wire logic [WIDTH-1:0] mem_wdata,
   output logic      [WIDTH-1:0] mem_rdata
);

   // Storage array, block RAM style
   logic [WIDTH-1:0] mem [DEPTH];

   ////////////////////////////////////////////////////////////////////////////
   // Single port, write first
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (mem_we) begin
         mem[mem_addr] <= mem_wdata;
         // New word shows on the read port
         mem_rdata     <= mem_wdata;
      end else begin
         // Registered read, one cycle after the address
         mem_rdata     <= mem[mem_addr];
      end
   end

endmodule : queue_ram

`default_nettype wire

// File: src/value_router.sv
`timescale 1ns/1ps
`default_nettype none

module value_router
   import pq_data_pkg::*;
   import pq_ctrl_pkg::*;
#(
   parameter int WIDTH = DEF_WIDTH,
   parameter int DEPTH = DEF_DEPTH,
   localparam int AW = $clog2(DEPTH)
) (
   input  wire logic [WIDTH-1:0] mem_rdata,
   input  wire logic [WIDTH-1:0] hold_value,
   input  wire route_t           route_mode,
   input  wire logic [AW:0]      count,
   output logic      [WIDTH-1:0] mem_wdata,
   output logic      [WIDTH-1:0] hold_next,
   output logic      [AW:0]      count_next,
   output logic                  swap,
   output logic                  at_end,
   output logic                  full_next,
   output logic                  empty_next
);

   ////////////////////////////////////////////////////////////////////////////
   // Constants
   ////////////////////////////////////////////////////////////////////////////

   // End marker for this word width
   localparam logic [WIDTH-1:0] END_WORD = {WIDTH{1'b1}};
   // Count value of a full queue
   localparam logic [AW:0] FULL_COUNT = (AW+1)'(DEPTH);

   ////////////////////////////////////////////////////////////////////////////
   // Routing step
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      // Neutral values, end marker on the write path
      mem_wdata  = END_WORD;
      hold_next  = hold_value;
      count_next = count;
      swap       = 1'b0;
      at_end     = 1'b0;

      case (route_mode)
         ROUTE_CMP: begin
            // Larger word stays in memory, smaller one moves on
            at_end = (mem_rdata == END_WORD);
            swap   = (hold_value > mem_rdata) || at_end;
            if (swap) begin
               mem_wdata = hold_value;
               hold_next = mem_rdata;
            end else begin
               mem_wdata = mem_rdata;
               hold_next = hold_value;
            end
         end

         ROUTE_SHIFT: begin
            // Slot i+1 copied down to slot i
            mem_wdata = mem_rdata;
         end

         ROUTE_INC: begin
            count_next = count + 1'b1;
         end

         ROUTE_DEC: begin
            count_next = count - 1'b1;
         end

         default: begin
            // Idle, defaults hold
         end
      endcase
   end

   // Flags follow the stepped count
   assign full_next  = (count_next == FULL_COUNT);
   assign empty_next = (count_next == '0);

endmodule : value_router

`default_nettype wire

// File: testbench/tb_pq_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pq_top;

   localparam int WIDTH      = 32;
   localparam int DEPTH      = 8;
   localparam int AW         = $clog2(DEPTH);
   // Cycle bound for every wait loop
   localparam int WAIT_LIMIT = 200;

   logic             clk;
   logic             rst;
   logic             push;
   logic [WIDTH-1:0] push_data;
   logic             pop;
   logic [WIDTH-1:0] pop_data;
   logic             pop_valid;
   logic             busy;
   logic             full;
   logic             empty;
   logic [AW:0]      count;

   // Expected contents, largest word first
   logic [WIDTH-1:0] model_q[$];
   integer           seed;
   string            cur_test;
   int               pass_count;
   int               err_count;
   int               test_checks;
   int               test_errs;
   // Busy samples seen by the latest idle wait
   int               last_busy_cycles;

   pq_top #(
      .WIDTH (WIDTH),
      .DEPTH (DEPTH)
   ) dut (
      .clk       (clk),
      .rst       (rst),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .pop_data  (pop_data),
      .pop_valid (pop_valid),
      .busy      (busy),
      .full      (full),
      .empty     (empty),
      .count     (count)
   );

   // 4 ns clock
   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Checks and bookkeeping
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_value(string label, logic [31:0] exp, logic [31:0] act);
      test_checks++;
      assert (exp === act) begin
         pass_count++;
      end else begin
         err_count++;
         test_errs++;
         $display("ERR %s/%s: expected %h, actual %h", cur_test, label, exp, act);
      end
   endtask

   task automatic report_timeout(string what);
      err_count++;
      test_errs++;
      $display("Timeout in %s: %s", cur_test, what);
   endtask

   task automatic begin_test(string name);
      cur_test    = name;
      test_checks = 0;
      test_errs   = 0;
   endtask

   task automatic end_test();
      $display("Test %s finished: %0d checks, %0d errors", cur_test, test_checks,
               test_errs);
   endtask

   // Random payload, top bit cleared so it never hits the end marker
   function automatic logic [31:0] random_word();
      return $random(seed) & 32'h7fff_ffff;
   endfunction

   // Sorted insert, descending
   function automatic void model_insert(logic [31:0] word);
      int pos;
      pos = 0;
      while (pos < model_q.size() && model_q[pos] >= word) begin
         pos++;
      end
      model_q.insert(pos, word);
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Bus-level tasks
   ////////////////////////////////////////////////////////////////////////////

   // Sampled on the falling edge, away from DUT updates
   task automatic wait_idle(string what);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (busy && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      // One loop pass per busy sample
      last_busy_cycles = cycles;
      if (busy) begin
         report_timeout(what);
      end
   endtask

   task automatic wait_busy_high(string what);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!busy && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!busy) begin
         report_timeout(what);
      end
   endtask

   // One-cycle push strobe, then wait for the scan to end
   task automatic push_word(logic [31:0] word);
      wait_idle("queue stayed busy before a push");
      @(posedge clk);
      #1;
      push      = 1'b1;
      push_data = word;
      @(posedge clk);
      #1;
      push      = 1'b0;
      wait_idle("push never finished");
   endtask

   task automatic push_and_track(logic [31:0] word);
      int slots;
      // Scan visits every held word plus the end marker
      slots = model_q.size() + 1;
      model_insert(word);
      push_word(word);
      check_value("push busy cycles", 32'(2 * slots + 1), 32'(last_busy_cycles));
      check_value("count after push", 32'(model_q.size()), 32'(count));
   endtask

   // Pop strobe, front word captured on the pop_valid pulse
   task automatic pop_word(output logic [31:0] word, output logic got);
      int   cycles;
      logic done;
      word   = '0;
      got    = 1'b0;
      done   = 1'b0;
      cycles = 0;
      wait_idle("queue stayed busy before a pop");
      @(posedge clk);
      #1;
      pop = 1'b1;
      @(posedge clk);
      #1;
      pop = 1'b0;
      while (!done && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
         if (pop_valid) begin
            got  = 1'b1;
            word = pop_data;
         end
         if (!busy) begin
            done = 1'b1;
         end
      end
      if (!done) begin
         report_timeout("pop never finished");
      end
   endtask

   task automatic pop_and_check();
      logic [31:0] word;
      logic        got;
      logic [31:0] exp;
      exp = model_q.pop_front();
      pop_word(word, got);
      check_value("pop_valid", 32'd1, 32'(got));
      check_value("pop word", exp, word);
      check_value("count after pop", 32'(model_q.size()), 32'(count));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] word;
      logic [31:0] dup;
      int          i;
      int          valid_seen;
      clk              = 1'b0;
      rst              = 1'b1;
      push             = 1'b0;
      push_data        = '0;
      pop              = 1'b0;
      seed             = 32'h881f_83fe;
      pass_count       = 0;
      err_count        = 0;
      cur_test         = "reset";
      test_checks      = 0;
      test_errs        = 0;
      last_busy_cycles = 0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;

      // Init sweep writes the end marker to every slot
      begin_test("reset_init");
      wait_busy_high("busy never rose for init");
      wait_idle("init never finished");
      // One end marker write per slot
      check_value("init busy cycles", DEPTH, 32'(1 + last_busy_cycles));
      check_value("empty", 32'd1, 32'(empty));
      check_value("full", 32'd0, 32'(full));
      check_value("count", 32'd0, 32'(count));
      end_test();

      begin_test("order");
      for (i = 0; i < 5; i++) begin
         push_and_track(random_word());
      end
      for (i = 0; i < 5; i++) begin
         pop_and_check();
      end
      check_value("empty", 32'd1, 32'(empty));
      end_test();

      begin_test("full");
      for (i = 0; i < DEPTH; i++) begin
         push_and_track(random_word());
      end
      check_value("full", 32'd1, 32'(full));
      check_value("empty", 32'd0, 32'(empty));
      // Rejected word, kept out of the model
      push_word(random_word());
      check_value("busy cycles of rejected push", 32'd0, 32'(last_busy_cycles));
      check_value("count after rejected push", DEPTH, 32'(count));
      for (i = 0; i < DEPTH; i++) begin
         pop_and_check();
      end
      check_value("full after drain", 32'd0, 32'(full));
      check_value("empty after drain", 32'd1, 32'(empty));
      end_test();

      begin_test("empty_pop");
      wait_idle("queue stayed busy before a pop");
      @(posedge clk);
      #1;
      pop = 1'b1;
      @(posedge clk);
      #1;
      pop = 1'b0;
      valid_seen = 0;
      // Fixed 50-cycle observation window
      repeat (50) begin
         @(negedge clk);
         if (pop_valid) begin
            valid_seen++;
         end
      end
      check_value("pop_valid pulses", 32'd0, 32'(valid_seen));
      check_value("count", 32'd0, 32'(count));
      end_test();

      begin_test("dup_interleave");
      dup  = 32'h0000_5a5a;
      word = random_word();
      // Same random word twice
      push_and_track(word);
      push_and_track(word);
      pop_and_check();
      for (i = 0; i < 12; i++) begin
         if (i % 3 == 0) begin
            push_and_track(dup);
         end else begin
            push_and_track(random_word());
         end
         if (i % 2 == 1) begin
            pop_and_check();
         end
      end
      while (model_q.size() > 0) begin
         pop_and_check();
      end
      check_value("empty at end", 32'd1, 32'(empty));
      end_test();

      $display("Checks passed: %0d, errors: %0d", pass_count, err_count);
      if (err_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule : tb_pq_top

`default_nettype wire
